//--- hw/sya_pkg.sv
//==============================
// Shared types and defaults for the systolic engine
// Sums are 32-bit signed, so very long channel counts can overflow
// Grid sizes below 2 are not supported
//==============================
package sya_pkg;

    //==============================
    // Data widths
    //==============================
    // Signed operands
    typedef logic signed [7:0]  act_t;
    typedef logic signed [7:0]  wgt_t;

    // Accumulator of one grid cell
    typedef logic signed [31:0] psum_t;

    // Operand beats per tile
    typedef logic [15:0]        chn_t;

    // Requantization bit position
    typedef logic [4:0]         shift_t;

    // Requantized output wraps modulo 256
    typedef logic [7:0]         ofm_t;

    //==============================
    // Controller states
    //==============================
    typedef enum logic [1:0] {
        IDLE,
        COMP,
        FLUSH,
        DRAIN
    } sya_state_e;

    // Default grid size
    parameter int DEF_NUM_ROW = 4;
    parameter int DEF_NUM_COL = 4;

endpackage

//--- hw/sya_pe.sv
//==============================
// One output-stationary MAC cell
// Operands hop one step east and south
//==============================
module sya_pe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           step,
    input  logic           clear,
    input  sya_pkg::act_t  act_in,
    input  sya_pkg::wgt_t  wgt_in,
    output sya_pkg::act_t  act_out,
    output sya_pkg::wgt_t  wgt_out,
    output sya_pkg::psum_t psum
);
    import sya_pkg::*;

    psum_t prod;

    // Sign extend before the multiply
    assign prod = psum_t'(act_in) * psum_t'(wgt_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum    <= '0;
            act_out <= '0;
            wgt_out <= '0;
        end else if (clear) begin
            // Start of a new tile
            psum    <= '0;
            act_out <= '0;
            wgt_out <= '0;
        end else if (step) begin
            psum    <= psum + prod;
            act_out <= act_in;
            wgt_out <= wgt_in;
        end
    end

endmodule

//--- hw/sya_pe_array.sv
//==============================
// NUM_ROW x NUM_COL MAC grid
// Activations flow east, weights flow south
// All accumulators are visible to the drain
//==============================
module sya_pe_array #(
    parameter int NUM_ROW = sya_pkg::DEF_NUM_ROW,
    parameter int NUM_COL = sya_pkg::DEF_NUM_COL
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       step,
    input  logic                                       clear,
    input  sya_pkg::act_t  [NUM_ROW-1:0]               act_west,
    input  sya_pkg::wgt_t  [NUM_COL-1:0]               wgt_north,
    output sya_pkg::psum_t [NUM_ROW-1:0][NUM_COL-1:0]  psum_grid
);
    import sya_pkg::*;

    // Links between cells with the far edge as the last entry
    act_t act_h [NUM_ROW][NUM_COL+1];
    wgt_t wgt_v [NUM_ROW+1][NUM_COL];

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_west
        assign act_h[r][0] = act_west[r];
    end

    for (genvar c = 0; c < NUM_COL; c++) begin : g_north
        assign wgt_v[0][c] = wgt_north[c];
    end

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_r
        for (genvar c = 0; c < NUM_COL; c++) begin : g_c
            sya_pe i_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .step    (step),
                .clear   (clear),
                .act_in  (act_h[r][c]),
                .wgt_in  (wgt_v[r][c]),
                .act_out (act_h[r][c+1]),
                .wgt_out (wgt_v[r+1][c]),
                .psum    (psum_grid[r][c])
            );
        end
    end

endmodule

//--- hw/sya_operand_skew.sv
//==============================
// Input skew for the grid edges
// Row r and column c lag by r and c steps
// Zeros are fed while inject is low
//==============================
module sya_operand_skew #(
    parameter int NUM_ROW = sya_pkg::DEF_NUM_ROW,
    parameter int NUM_COL = sya_pkg::DEF_NUM_COL
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        step,
    input  logic                        inject,
    input  logic                        clear,
    input  sya_pkg::act_t [NUM_ROW-1:0] in_act,
    input  sya_pkg::wgt_t [NUM_COL-1:0] in_wgt,
    output sya_pkg::act_t [NUM_ROW-1:0] act_west,
    output sya_pkg::wgt_t [NUM_COL-1:0] wgt_north
);
    import sya_pkg::*;

    //==============================
    // Activation rows
    //==============================
    for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
        act_t src;

        assign src = inject ? in_act[r] : '0;

        if (r == 0) begin : g_pass
            assign act_west[r] = src;
        end else begin : g_dly
            act_t sr [r];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < r; i++) begin
                        sr[i] <= '0;
                    end
                end else if (clear) begin
                    for (int i = 0; i < r; i++) begin
                        sr[i] <= '0;
                    end
                end else if (step) begin
                    sr[0] <= src;
                    for (int i = 1; i < r; i++) begin
                        sr[i] <= sr[i-1];
                    end
                end
            end

            assign act_west[r] = sr[r-1];
        end
    end

    //==============================
    // Weight columns
    //==============================
    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        wgt_t src;

        assign src = inject ? in_wgt[c] : '0;

        if (c == 0) begin : g_pass
            assign wgt_north[c] = src;
        end else begin : g_dly
            wgt_t sr [c];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < c; i++) begin
                        sr[i] <= '0;
                    end
                end else if (clear) begin
                    for (int i = 0; i < c; i++) begin
                        sr[i] <= '0;
                    end
                end else if (step) begin
                    sr[0] <= src;
                    for (int i = 1; i < c; i++) begin
                        sr[i] <= sr[i-1];
                    end
                end
            end

            assign wgt_north[c] = sr[c-1];
        end
    end

endmodule

//--- hw/sya_ctrl.sv
//==============================
// Tile controller with one tile in flight
// A channel count of zero runs as one beat
// Flush lasts NUM_ROW+NUM_COL-2 cycles, one step each
//==============================
module sya_ctrl #(
    parameter int NUM_ROW = sya_pkg::DEF_NUM_ROW,
    parameter int NUM_COL = sya_pkg::DEF_NUM_COL
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_valid,
    input  sya_pkg::chn_t   cfg_chn,
    input  sya_pkg::shift_t cfg_shift,
    input  sya_pkg::ofm_t   cfg_zp,
    input  logic            in_valid,
    input  logic            drain_done,
    output logic            cfg_ready,
    output logic            in_ready,
    output logic            step,
    output logic            inject,
    output logic            clear,
    output logic            drain_en,
    output sya_pkg::shift_t shift,
    output sya_pkg::ofm_t   zp
);
    import sya_pkg::*;

    localparam int FW = $clog2(NUM_ROW + NUM_COL);
    localparam logic [FW-1:0] FLUSH_END = FW'(NUM_ROW + NUM_COL - 3);

    sya_state_e    state;
    sya_state_e    state_nxt;
    chn_t          chn_q;
    chn_t          chn_cnt;
    logic [FW-1:0] flush_cnt;
    logic          beat;
    logic          last_beat;

    assign cfg_ready = (state == IDLE);
    assign in_ready  = (state == COMP);
    assign beat      = in_valid & in_ready;
    assign last_beat = beat & (chn_cnt == chn_q - 1'b1);

    // Grid pacing
    assign clear    = cfg_valid & cfg_ready;
    assign step     = beat | (state == FLUSH);
    assign inject   = (state == COMP);
    assign drain_en = (state == DRAIN);

    //==============================
    // State machine
    //==============================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (clear) state_nxt = COMP;
            COMP:    if (last_beat) state_nxt = FLUSH;
            FLUSH:   if (flush_cnt == FLUSH_END) state_nxt = DRAIN;
            DRAIN:   if (drain_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            chn_cnt   <= '0;
            flush_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (clear) begin
                chn_cnt <= '0;
            end else if (beat) begin
                chn_cnt <= chn_cnt + 1'b1;
            end
            // Free-running only inside FLUSH
            if (state == FLUSH) begin
                flush_cnt <= flush_cnt + 1'b1;
            end else begin
                flush_cnt <= '0;
            end
        end
    end

    // Configuration capture on accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chn_q <= chn_t'(1);
            shift <= '0;
            zp    <= '0;
        end else if (clear) begin
            chn_q <= (cfg_chn == '0) ? chn_t'(1) : cfg_chn;
            shift <= cfg_shift;
            zp    <= cfg_zp;
        end
    end

endmodule

//--- hw/sya_requant_drain.sv
//==============================
// Row drain with ReLU and requantization
// Sums must stay frozen while drain_en is high
// Output data is combinational from the row counter
//==============================
module sya_requant_drain #(
    parameter int NUM_ROW = sya_pkg::DEF_NUM_ROW,
    parameter int NUM_COL = sya_pkg::DEF_NUM_COL
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      drain_en,
    input  sya_pkg::psum_t [NUM_ROW-1:0][NUM_COL-1:0] psum_grid,
    input  sya_pkg::shift_t                           shift,
    input  sya_pkg::ofm_t                             zp,
    input  logic                                      out_ready,
    output logic                                      out_valid,
    output sya_pkg::ofm_t  [NUM_COL-1:0]              out_ofm,
    output logic [$clog2(NUM_ROW)-1:0]                out_row,
    output logic                                      out_last,
    output logic                                      drain_done
);
    import sya_pkg::*;

    localparam int RW = $clog2(NUM_ROW);
    localparam logic [RW-1:0] LAST_ROW = RW'(NUM_ROW - 1);

    logic [RW-1:0]        row_q;
    psum_t [NUM_COL-1:0]  row_sel;
    logic                 hs;

    assign out_valid  = drain_en;
    assign out_row    = row_q;
    assign out_last   = drain_en & (row_q == LAST_ROW);
    assign hs         = out_valid & out_ready;
    assign drain_done = hs & out_last;

    assign row_sel = psum_grid[row_q];

    //==============================
    // ReLU and requantize
    //==============================
    always_comb begin
        psum_t shifted;
        for (int c = 0; c < NUM_COL; c++) begin
            shifted = row_sel[c] >>> shift;
            if (row_sel[c] < 0) begin
                out_ofm[c] = '0;
            end else begin
                // Zero point add wraps at 8 bits
                out_ofm[c] = shifted[7:0] + zp;
            end
        end
    end

    // Row counter wraps after the last row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q <= '0;
        end else if (hs) begin
            row_q <= out_last ? '0 : row_q + 1'b1;
        end
    end

endmodule

//--- hw/sya_top.sv
//==============================
// Systolic matrix engine top
// Configure once, stream cfg_chn beats, drain NUM_ROW rows
// The next configuration waits for the end of the drain
//==============================
module sya_top #(
    parameter int NUM_ROW = sya_pkg::DEF_NUM_ROW,
    parameter int NUM_COL = sya_pkg::DEF_NUM_COL
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfg_valid,
    input  sya_pkg::chn_t                cfg_chn,
    input  sya_pkg::shift_t              cfg_shift,
    input  sya_pkg::ofm_t                cfg_zp,
    output logic                         cfg_ready,
    input  logic                         in_valid,
    input  sya_pkg::act_t [NUM_ROW-1:0]  in_act,
    input  sya_pkg::wgt_t [NUM_COL-1:0]  in_wgt,
    output logic                         in_ready,
    output logic                         out_valid,
    output sya_pkg::ofm_t [NUM_COL-1:0]  out_ofm,
    output logic [$clog2(NUM_ROW)-1:0]   out_row,
    output logic                         out_last,
    input  logic                         out_ready
);
    import sya_pkg::*;

    logic                              step;
    logic                              inject;
    logic                              clear;
    logic                              drain_en;
    logic                              drain_done;
    shift_t                            shift;
    ofm_t                              zp;
    act_t  [NUM_ROW-1:0]               act_west;
    wgt_t  [NUM_COL-1:0]               wgt_north;
    psum_t [NUM_ROW-1:0][NUM_COL-1:0]  psum_grid;

    sya_ctrl #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) i_ctrl (
        .clk        (clk),        .rst_n      (rst_n),
        .cfg_valid  (cfg_valid),  .cfg_chn    (cfg_chn),
        .cfg_shift  (cfg_shift),  .cfg_zp     (cfg_zp),
        .in_valid   (in_valid),   .drain_done (drain_done),
        .cfg_ready  (cfg_ready),  .in_ready   (in_ready),
        .step       (step),       .inject     (inject),
        .clear      (clear),      .drain_en   (drain_en),
        .shift      (shift),      .zp         (zp)
    );

    sya_operand_skew #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) i_skew (
        .clk      (clk),      .rst_n     (rst_n),
        .step     (step),     .inject    (inject),
        .clear    (clear),    .in_act    (in_act),
        .in_wgt   (in_wgt),   .act_west  (act_west),
        .wgt_north(wgt_north)
    );

    sya_pe_array #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) i_array (
        .clk      (clk),      .rst_n     (rst_n),
        .step     (step),     .clear     (clear),
        .act_west (act_west), .wgt_north (wgt_north),
        .psum_grid(psum_grid)
    );

    sya_requant_drain #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) i_drain (
        .clk       (clk),       .rst_n      (rst_n),
        .drain_en  (drain_en),  .psum_grid  (psum_grid),
        .shift     (shift),     .zp         (zp),
        .out_ready (out_ready), .out_valid  (out_valid),
        .out_ofm   (out_ofm),   .out_row    (out_row),
        .out_last  (out_last),  .drain_done (drain_done)
    );

endmodule

//--- sim/sya_props.sv
//==============================
// Handshake rules of sya_top, attached by bind
// Checked only while out of reset
//==============================
module sya_props #(
    parameter int NUM_ROW = sya_pkg::DEF_NUM_ROW,
    parameter int NUM_COL = sya_pkg::DEF_NUM_COL
) (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         cfg_ready,
    input logic                         in_ready,
    input logic                         out_valid,
    input logic                         out_ready,
    input logic                         out_last,
    input logic [$clog2(NUM_ROW)-1:0]   out_row,
    input sya_pkg::ofm_t [NUM_COL-1:0]  out_ofm
);

    // Config and operand sides never open together
    ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(cfg_ready && in_ready))
        else $error("cfg_ready and in_ready are high in the same cycle");

    // A stalled row keeps its data
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_ofm) && $stable(out_row) && $stable(out_last)))
        else $error("result row changed while out_ready was low");

    // No result while idle
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_ready |-> !out_valid)
        else $error("out_valid is high while cfg_ready is high");

endmodule

bind sya_top sya_props #(
    .NUM_ROW (NUM_ROW),
    .NUM_COL (NUM_COL)
) i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_ready (cfg_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last),
    .out_row   (out_row),
    .out_ofm   (out_ofm)
);

//--- sim/tb_sya.sv
//==============================
// Testbench for the systolic engine on the default 4x4 grid
// Operands come from a fixed seed, results from a dot product model
// The run stops at the first mismatch
//==============================
module tb_sya;
    import sya_pkg::*;

    localparam int NUM_ROW   = DEF_NUM_ROW;
    localparam int NUM_COL   = DEF_NUM_COL;
    localparam int MAX_CHN   = 8;
    // Longest run of stalled cycles on either handshake
    localparam int MAX_STALL = 3;
    // Tiles below carry 8, 8, 6, 6, 6, 5 and 1 beats
    localparam int NUM_TILES = 7;
    localparam int TOTAL_CHN = 40;
    localparam int CYCLE_LIMIT = 16 + 4 * (TOTAL_CHN + NUM_TILES * (2 * NUM_ROW + NUM_COL)
        + MAX_STALL * (TOTAL_CHN + NUM_TILES * NUM_ROW));

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       cfg_valid;
    chn_t                       cfg_chn;
    shift_t                     cfg_shift;
    ofm_t                       cfg_zp;
    logic                       cfg_ready;
    logic                       in_valid;
    act_t [NUM_ROW-1:0]         in_act;
    wgt_t [NUM_COL-1:0]         in_wgt;
    logic                       in_ready;
    logic                       out_valid;
    ofm_t [NUM_COL-1:0]         out_ofm;
    logic [$clog2(NUM_ROW)-1:0] out_row;
    logic                       out_last;
    logic                       out_ready;

    int   seed = 32'hc7f1_a259;
    int   cycle_cnt = 0;
    bit   held_prev = 1'b0;
    int   hold_chn;
    int   hold_shift;
    int   hold_zp;
    act_t act_mem [MAX_CHN][NUM_ROW];
    wgt_t wgt_mem [MAX_CHN][NUM_COL];

    sya_top #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) i_dut (
        .clk       (clk),       .rst_n     (rst_n),
        .cfg_valid (cfg_valid), .cfg_chn   (cfg_chn),
        .cfg_shift (cfg_shift), .cfg_zp    (cfg_zp),
        .cfg_ready (cfg_ready), .in_valid  (in_valid),
        .in_act    (in_act),    .in_wgt    (in_wgt),
        .in_ready  (in_ready),  .out_valid (out_valid),
        .out_ofm   (out_ofm),   .out_row   (out_row),
        .out_last  (out_last),  .out_ready (out_ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, tests not finished after %0d cycles", cycle_cnt));
        end
    end

    //==============================
    // Reporting and random helpers
    //==============================
    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, int expected, int actual);
        if (expected != actual) begin
            abort_run($sformatf("mismatch %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    function automatic int rand_below(int n);
        int v;
        v = $random(seed) & 32'h7fff_ffff;
        return v % n;
    endfunction

    // Stalls never run longer than MAX_STALL cycles
    function automatic bit stall_now(int pct, int run);
        if (pct == 0 || run >= MAX_STALL) begin
            return 1'b0;
        end
        return rand_below(100) < pct;
    endfunction

    task automatic fill_random(int chn);
        for (int b = 0; b < chn; b++) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                act_mem[b][r] = act_t'($random(seed));
            end
            for (int c = 0; c < NUM_COL; c++) begin
                wgt_mem[b][c] = wgt_t'($random(seed));
            end
        end
    endtask

    // Positive activations and negative weights on odd columns
    task automatic fill_signed_cols(int chn);
        for (int b = 0; b < chn; b++) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                act_mem[b][r] = act_t'(1 + rand_below(127));
            end
            for (int c = 0; c < NUM_COL; c++) begin
                if (c % 2 == 1) begin
                    wgt_mem[b][c] = wgt_t'(-1 - rand_below(128));
                end else begin
                    wgt_mem[b][c] = wgt_t'(rand_below(128));
                end
            end
        end
    endtask

    // Dot product over the beats, then ReLU and requantize
    function automatic int model_ofm(int r, int c, int chn, int shift, int zp);
        int sum;
        sum = 0;
        for (int b = 0; b < chn; b++) begin
            sum += int'(act_mem[b][r]) * int'(wgt_mem[b][c]);
        end
        if (sum < 0) begin
            return 0;
        end
        return ((sum >> shift) + zp) % 256;
    endfunction

    //==============================
    // One tile through configure, feed and drain
    //==============================
    task automatic run_tile(string name, int chn, int shift, int zp,
                            int gap_pct, int stall_pct, bit hold);
        int  b;
        int  row;
        int  run;
        int  lat;
        int  waited;
        bit  seen;
        bit  accepted;

        cfg_valid <= 1'b1;
        cfg_chn   <= chn_t'(chn);
        cfg_shift <= shift_t'(shift);
        cfg_zp    <= ofm_t'(zp);
        waited    = 0;
        accepted  = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            waited++;
            accepted = cfg_valid && cfg_ready;
        end
        // A pending config goes in right after the previous drain
        if (held_prev) begin
            check_value({name, " accept delay"}, 1, waited);
        end
        if (hold) begin
            cfg_chn   <= chn_t'(hold_chn);
            cfg_shift <= shift_t'(hold_shift);
            cfg_zp    <= ofm_t'(hold_zp);
        end else begin
            cfg_valid <= 1'b0;
        end

        b   = 0;
        run = 0;
        while (b < chn) begin
            if (stall_now(gap_pct, run)) begin
                in_valid <= 1'b0;
                run++;
            end else begin
                in_valid <= 1'b1;
                run = 0;
                for (int r = 0; r < NUM_ROW; r++) begin
                    in_act[r] <= act_mem[b][r];
                end
                for (int c = 0; c < NUM_COL; c++) begin
                    in_wgt[c] <= wgt_mem[b][c];
                end
            end
            @(posedge clk);
            check_value({name, " cfg_ready busy"}, 0, int'(cfg_ready));
            check_value({name, " out_valid early"}, 0, int'(out_valid));
            if (in_valid && in_ready) begin
                b++;
            end
        end
        in_valid <= 1'b0;

        row  = 0;
        run  = 0;
        lat  = 0;
        seen = 1'b0;
        while (row < NUM_ROW) begin
            if (stall_now(stall_pct, run)) begin
                out_ready <= 1'b0;
                run++;
            end else begin
                out_ready <= 1'b1;
                run = 0;
            end
            @(posedge clk);
            check_value({name, " cfg_ready busy"}, 0, int'(cfg_ready));
            if (!seen) begin
                lat++;
                if (out_valid) begin
                    seen = 1'b1;
                    check_value({name, " drain latency"}, NUM_ROW + NUM_COL - 1, lat);
                end
            end
            if (out_valid && out_ready) begin
                check_value({name, " out_row"}, row, int'(out_row));
                check_value({name, " out_last"}, (row == NUM_ROW - 1) ? 1 : 0, int'(out_last));
                for (int c = 0; c < NUM_COL; c++) begin
                    check_value($sformatf("%s row%0d col%0d", name, row, c),
                                model_ofm(row, c, chn, shift, zp), int'(out_ofm[c]));
                end
                row++;
            end
        end
        held_prev = hold;
    endtask

    //==============================
    // Test sequence
    //==============================
    initial begin
        int shift_a;
        int zp_a;

        rst_n     <= 1'b0;
        cfg_valid <= 1'b0;
        cfg_chn   <= '0;
        cfg_shift <= '0;
        cfg_zp    <= '0;
        in_valid  <= 1'b0;
        in_act    <= '0;
        in_wgt    <= '0;
        out_ready <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        check_value("reset cfg_ready", 1, int'(cfg_ready));
        check_value("reset in_ready", 0, int'(in_ready));
        check_value("reset out_valid", 0, int'(out_valid));
        check_value("reset out_last", 0, int'(out_last));

        // Same operands with and without handshake stalls
        fill_random(8);
        shift_a = rand_below(12);
        zp_a    = rand_below(256);
        run_tile("random_chn8", 8, shift_a, zp_a, 0, 0, 1'b0);
        run_tile("stall_chn8", 8, shift_a, zp_a, 35, 35, 1'b0);

        // Negative sums on odd columns and a wrapping zero point
        fill_signed_cols(6);
        run_tile("relu_shift0", 6, 0, 8'hf0, 0, 0, 1'b0);
        run_tile("relu_shift4", 6, 4, 8'h80, 0, 20, 1'b0);
        run_tile("relu_shift9", 6, 9, 8'hff, 20, 0, 1'b0);

        // Next config waits with cfg_valid high through a whole tile
        hold_chn   = 1;
        hold_shift = 3;
        hold_zp    = 8'h21;
        fill_random(5);
        run_tile("held_cfg_chn5", 5, 2, 8'h05, 20, 20, 1'b1);
        fill_random(1);
        run_tile("single_beat", hold_chn, hold_shift, hold_zp, 0, 0, 1'b0);

        @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- compile.f
hw/sya_pkg.sv
hw/sya_pe.sv
hw/sya_pe_array.sv
hw/sya_operand_skew.sv
hw/sya_ctrl.sv
hw/sya_requant_drain.sv
hw/sya_top.sv
sim/sya_props.sv
sim/tb_sya.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_sya
RTL_TOP    := sya_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
